//--- Bender.yml
package:
  name: soc_fabric

sources:
  - hdl/soc_pkg.sv
  - hdl/wb_intercon.sv
  - hdl/wb_ram.sv
  - hdl/wb_data_resize.sv
  - hdl/wb_uart_tx.sv
  - hdl/soc_top.sv
  - target: test
    files:
      - testbench/tb_soc_top.sv

//--- flist.f
hdl/soc_pkg.sv
hdl/wb_intercon.sv
hdl/wb_ram.sv
hdl/wb_data_resize.sv
hdl/wb_uart_tx.sv
hdl/soc_top.sv
testbench/tb_soc_top.sv

//--- hdl/soc_pkg.sv
package soc_pkg;

   // 32-bit Wishbone request, master to slave
   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic        we;
      logic        cyc;
      logic        stb;
   } wb_m2s_t;

   // 32-bit Wishbone response
   typedef struct packed {
      logic [31:0] dat;
      logic        ack;
      logic        err;
   } wb_s2m_t;

   // 8-bit peripheral bus, no byte selects
   typedef struct packed {
      logic [31:0] adr;
      logic [7:0]  dat;
      logic        we;
      logic        cyc;
      logic        stb;
   } wb8_m2s_t;

   typedef struct packed {
      logic [7:0] dat;
      logic       ack;
      logic       err;
   } wb8_s2m_t;

   ///////////////////////////////////////////////////////////////////////
   // Address map
   ///////////////////////////////////////////////////////////////////////

   localparam int          MEM_ADR_BITS = 8;
   localparam logic [31:0] RAM_BASE     = 32'h0000_0000;
   localparam logic [31:0] RAM_MASK     = 32'h0000_03FF;
   localparam logic [31:0] UART_BASE    = 32'h9000_0000;
   localparam logic [31:0] UART_MASK    = 32'h0000_0003;

   // Serial timing, fixed bit time
   localparam int UART_CLKS_PER_BIT = 4;
   localparam int UART_CNT_BITS     =
      (UART_CLKS_PER_BIT > 1) ? $clog2(UART_CLKS_PER_BIT) : 1;

   // UART register byte offsets
   localparam logic [1:0] UART_REG_TX     = 2'd0;
   localparam logic [1:0] UART_REG_STATUS = 2'd1;

endpackage

//--- hdl/soc_top.sv
module soc_top (
   input  logic             wb_clk_i,
   input  logic             rst_n_i,
   input  soc_pkg::wb_m2s_t ibus_m2s_i,
   output soc_pkg::wb_s2m_t ibus_s2m_o,
   input  soc_pkg::wb_m2s_t dbus_m2s_i,
   output soc_pkg::wb_s2m_t dbus_s2m_o,
   output logic             uart_tx_o
);
   import soc_pkg::*;

   wb_m2s_t  mem_m2s;
   wb_s2m_t  mem_s2m;
   wb_m2s_t  uart_m2s;
   wb_s2m_t  uart_s2m;
   // UART side after the width adapter
   wb8_m2s_t uart8_m2s;
   wb8_s2m_t uart8_s2m;

   ///////////////////////////////////////////////////////////////////////
   // Wishbone interconnect
   ///////////////////////////////////////////////////////////////////////
   wb_intercon wb_intercon0 (
      .wb_clk_i   (wb_clk_i),
      .rst_n_i    (rst_n_i),
      .ibus_m2s_i (ibus_m2s_i),
      .ibus_s2m_o (ibus_s2m_o),
      .dbus_m2s_i (dbus_m2s_i),
      .dbus_s2m_o (dbus_s2m_o),
      .mem_m2s_o  (mem_m2s),
      .mem_s2m_i  (mem_s2m),
      .uart_m2s_o (uart_m2s),
      .uart_s2m_i (uart_s2m)
   );

   ///////////////////////////////////////////////////////////////////////
   // Main RAM
   ///////////////////////////////////////////////////////////////////////
   wb_ram wb_ram0 (
      .wb_clk_i (wb_clk_i),
      .rst_n_i  (rst_n_i),
      .wb_m2s_i (mem_m2s),
      .wb_s2m_o (mem_s2m)
   );

   ///////////////////////////////////////////////////////////////////////
   // UART
   ///////////////////////////////////////////////////////////////////////
   wb_data_resize wb_data_resize_uart0 (
      .wbm_m2s_i (uart_m2s),
      .wbm_s2m_o (uart_s2m),
      .wbs_m2s_o (uart8_m2s),
      .wbs_s2m_i (uart8_s2m)
   );

   wb_uart_tx wb_uart_tx0 (
      .wb_clk_i (wb_clk_i),
      .rst_n_i  (rst_n_i),
      .wb_m2s_i (uart8_m2s),
      .wb_s2m_o (uart8_s2m),
      .tx_o     (uart_tx_o)
   );

endmodule

//--- hdl/wb_data_resize.sv
module wb_data_resize (
   // 32-bit side, from the interconnect
   input  soc_pkg::wb_m2s_t  wbm_m2s_i,
   output soc_pkg::wb_s2m_t  wbm_s2m_o,
   // 8-bit side, to the peripheral
   output soc_pkg::wb8_m2s_t wbs_m2s_o,
   input  soc_pkg::wb8_s2m_t wbs_s2m_i
);

   logic [1:0] lane;
   logic       lane_ok;

   // Only one-hot byte selects map onto the narrow bus
   always_comb begin
      lane_ok = 1'b1;
      case (wbm_m2s_i.sel)
         4'b0001: lane = 2'd0;
         4'b0010: lane = 2'd1;
         4'b0100: lane = 2'd2;
         4'b1000: lane = 2'd3;
         default: begin
            lane    = 2'd0;
            lane_ok = 1'b0;
         end
      endcase
   end

   always_comb begin
      wbs_m2s_o.adr = {wbm_m2s_i.adr[31:2], lane};
      wbs_m2s_o.dat = wbm_m2s_i.dat[8*lane +: 8];
      wbs_m2s_o.we  = wbm_m2s_i.we;
      wbs_m2s_o.cyc = wbm_m2s_i.cyc & lane_ok;
      wbs_m2s_o.stb = wbm_m2s_i.stb & lane_ok;
   end

   // Read byte goes back on its own lane
   always_comb begin
      wbm_s2m_o.dat = {24'd0, wbs_s2m_i.dat} << {lane, 3'b000};
      wbm_s2m_o.ack = wbs_s2m_i.ack & lane_ok;
      wbm_s2m_o.err = wbs_s2m_i.err
                    | (wbm_m2s_i.cyc & wbm_m2s_i.stb & ~lane_ok);
   end

endmodule

//--- hdl/wb_intercon.sv
module wb_intercon (
   input  logic             wb_clk_i,
   input  logic             rst_n_i,
   // Masters
   input  soc_pkg::wb_m2s_t ibus_m2s_i,
   output soc_pkg::wb_s2m_t ibus_s2m_o,
   input  soc_pkg::wb_m2s_t dbus_m2s_i,
   output soc_pkg::wb_s2m_t dbus_s2m_o,
   // Slaves
   output soc_pkg::wb_m2s_t mem_m2s_o,
   input  soc_pkg::wb_s2m_t mem_s2m_i,
   output soc_pkg::wb_m2s_t uart_m2s_o,
   input  soc_pkg::wb_s2m_t uart_s2m_i
);
   import soc_pkg::*;

   logic        gnt_i_q;
   logic        gnt_d_q;
   logic        done_q;
   wb_m2s_t     m2s;
   wb_s2m_t     slv_s2m;
   logic        sel_ram;
   logic        sel_uart;
   logic        sel_none;
   logic        fwd_stb;
   logic        resp_ack;
   logic        resp_err;
   logic        ibus_ack_q;
   logic        ibus_err_q;
   logic        dbus_ack_q;
   logic        dbus_err_q;
   logic [31:0] resp_dat_q;

   // Granted master's request or an idle bus
   always_comb begin
      m2s = '0;
      if (gnt_d_q) begin
         m2s = dbus_m2s_i;
      end else if (gnt_i_q) begin
         m2s = ibus_m2s_i;
      end
   end

   // Address decode
   assign sel_ram  = (m2s.adr & ~RAM_MASK) == RAM_BASE;
   assign sel_uart = (m2s.adr & ~UART_MASK) == UART_BASE;
   assign sel_none = ~sel_ram & ~sel_uart;

   // Strobe stays blocked from the answer until the master drops it
   assign fwd_stb = m2s.cyc & m2s.stb & ~done_q;

   always_comb begin
      mem_m2s_o      = m2s;
      mem_m2s_o.cyc  = m2s.cyc & sel_ram;
      mem_m2s_o.stb  = fwd_stb & sel_ram;
      uart_m2s_o     = m2s;
      uart_m2s_o.cyc = m2s.cyc & sel_uart;
      uart_m2s_o.stb = fwd_stb & sel_uart;
   end

   always_comb begin
      slv_s2m = '0;
      if (sel_ram) begin
         slv_s2m = mem_s2m_i;
      end else if (sel_uart) begin
         slv_s2m = uart_s2m_i;
      end
   end

   // Unmapped space gets err from here
   assign resp_ack = fwd_stb & slv_s2m.ack;
   assign resp_err = fwd_stb & (slv_s2m.err | sel_none);

   ///////////////////////////////////////////////////////////////////////
   // Grant and response registers
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         gnt_i_q    <= 1'b0;
         gnt_d_q    <= 1'b0;
         done_q     <= 1'b0;
         ibus_ack_q <= 1'b0;
         ibus_err_q <= 1'b0;
         dbus_ack_q <= 1'b0;
         dbus_err_q <= 1'b0;
      end else begin
         // Data master wins a tie
         if (!gnt_i_q && !gnt_d_q) begin
            gnt_d_q <= dbus_m2s_i.cyc;
            gnt_i_q <= ~dbus_m2s_i.cyc & ibus_m2s_i.cyc;
         end else if (!m2s.cyc) begin
            gnt_d_q <= 1'b0;
            gnt_i_q <= 1'b0;
         end
         if (resp_ack || resp_err) begin
            done_q <= 1'b1;
         end else if (!m2s.stb) begin
            done_q <= 1'b0;
         end
         ibus_ack_q <= gnt_i_q & resp_ack;
         ibus_err_q <= gnt_i_q & resp_err;
         dbus_ack_q <= gnt_d_q & resp_ack;
         dbus_err_q <= gnt_d_q & resp_err;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (resp_ack) begin
         resp_dat_q <= slv_s2m.dat;
      end
   end

   always_comb begin
      ibus_s2m_o.dat = resp_dat_q;
      ibus_s2m_o.ack = ibus_ack_q;
      ibus_s2m_o.err = ibus_err_q;
      dbus_s2m_o.dat = resp_dat_q;
      dbus_s2m_o.ack = dbus_ack_q;
      dbus_s2m_o.err = dbus_err_q;
   end

   // A response only reaches the master that still owns the bus
   a_single_grant: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      !(gnt_i_q && gnt_d_q)
      && (!(ibus_s2m_o.ack || ibus_s2m_o.err) || gnt_i_q)
      && (!(dbus_s2m_o.ack || dbus_s2m_o.err) || gnt_d_q));

   a_ibus_resp: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      !(ibus_s2m_o.ack && ibus_s2m_o.err));

   a_dbus_resp: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      !(dbus_s2m_o.ack && dbus_s2m_o.err));

endmodule

//--- hdl/wb_ram.sv
module wb_ram (
   input  logic             wb_clk_i,
   input  logic             rst_n_i,
   input  soc_pkg::wb_m2s_t wb_m2s_i,
   output soc_pkg::wb_s2m_t wb_s2m_o
);
   import soc_pkg::*;

   logic [31:0]             mem [2**MEM_ADR_BITS];
   logic [MEM_ADR_BITS-1:0] word_adr;
   logic                    access;
   logic                    ack_q;
   logic [31:0]             rd_dat_q;

   // Word index sits above the byte offset
   assign word_adr = wb_m2s_i.adr[MEM_ADR_BITS+1:2];

   // One access per strobe, ack cycle excluded
   assign access = wb_m2s_i.cyc & wb_m2s_i.stb & ~ack_q;

   always_ff @(posedge wb_clk_i) begin
      if (access) begin
         if (wb_m2s_i.we) begin
            for (int b = 0; b < 4; b++) begin
               if (wb_m2s_i.sel[b]) begin
                  mem[word_adr][8*b +: 8] <= wb_m2s_i.dat[8*b +: 8];
               end
            end
         end
         rd_dat_q <= mem[word_adr];
      end
   end

   always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   always_comb begin
      wb_s2m_o.dat = rd_dat_q;
      wb_s2m_o.ack = ack_q;
      wb_s2m_o.err = 1'b0;
   end

endmodule

//--- hdl/wb_uart_tx.sv
module wb_uart_tx (
   input  logic              wb_clk_i,
   input  logic              rst_n_i,
   input  soc_pkg::wb8_m2s_t wb_m2s_i,
   output soc_pkg::wb8_s2m_t wb_s2m_o,
   output logic              tx_o
);
   import soc_pkg::*;

   logic                     ack_q;
   logic [7:0]               rd_dat_q;
   logic [7:0]               tx_hold_q;
   logic                     busy_q;
   logic [UART_CNT_BITS-1:0] clk_cnt_q;
   logic [3:0]               bit_idx_q;
   logic [9:0]               shift_q;
   logic                     req;
   logic                     is_tx;
   logic                     bit_end;
   logic                     frame_end;
   logic                     take;
   logic                     tx_load;

   assign req   = wb_m2s_i.cyc & wb_m2s_i.stb & ~ack_q;
   // Only offset bit 0 is decoded
   assign is_tx = wb_m2s_i.adr[0] == UART_REG_TX[0];

   assign bit_end   = busy_q && (clk_cnt_q == UART_CNT_BITS'(UART_CLKS_PER_BIT - 1));
   assign frame_end = bit_end && (bit_idx_q == 4'd9);

   // TX write waits for the stop bit of the running frame
   assign take    = req & (~(wb_m2s_i.we & is_tx) | ~busy_q | frame_end);
   assign tx_load = take & wb_m2s_i.we & is_tx;

   ///////////////////////////////////////////////////////////////////////
   // Register access
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q     <= 1'b0;
         tx_hold_q <= 8'd0;
      end else begin
         ack_q <= take;
         if (tx_load) begin
            tx_hold_q <= wb_m2s_i.dat;
         end
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (take) begin
         rd_dat_q <= is_tx ? tx_hold_q : {7'd0, busy_q};
      end
   end

   always_comb begin
      wb_s2m_o.dat = rd_dat_q;
      wb_s2m_o.ack = ack_q;
      wb_s2m_o.err = 1'b0;
   end

   ///////////////////////////////////////////////////////////////////////
   // Serial shifter
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q    <= 1'b0;
         clk_cnt_q <= '0;
         bit_idx_q <= 4'd0;
         shift_q   <= '1;
      end else if (tx_load) begin
         // Stop, data LSB first, start
         shift_q   <= {1'b1, wb_m2s_i.dat, 1'b0};
         busy_q    <= 1'b1;
         clk_cnt_q <= '0;
         bit_idx_q <= 4'd0;
      end else if (busy_q) begin
         if (bit_end) begin
            clk_cnt_q <= '0;
            shift_q   <= {1'b1, shift_q[9:1]};
            if (frame_end) begin
               busy_q <= 1'b0;
            end else begin
               bit_idx_q <= bit_idx_q + 4'd1;
            end
         end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
         end
      end
   end

   assign tx_o = shift_q[0];

   a_idle_line: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      !busy_q |-> tx_o);

endmodule

//--- testbench/tb_soc_top.sv
module tb_soc_top;
   import soc_pkg::*;

   localparam int N_WORDS     = 16;
   localparam int N_RAND      = 32;
   localparam int N_CONC      = 8;
   localparam int N_FRAMES    = 4;
   localparam int N_XFERS     = 2 * N_WORDS + N_RAND + 2 * N_CONC + 11;
   localparam int WATCHDOG_CYCLES =
      N_XFERS * 60 + N_FRAMES * 10 * UART_CLKS_PER_BIT * 2;
   localparam int XFER_LIMIT  = 4 * 10 * UART_CLKS_PER_BIT;
   localparam int FRAME_LIMIT = 3 * 10 * UART_CLKS_PER_BIT;

   // Status register lane and its busy bit on the 32-bit bus
   localparam logic [3:0]  STATUS_SEL  = 4'b0001 << UART_REG_STATUS;
   localparam logic [31:0] STATUS_BUSY = 32'h1 << (8 * UART_REG_STATUS);

   logic        clk = 1'b0;
   logic        rst_n;
   wb_m2s_t     ibus_m2s;
   wb_s2m_t     ibus_s2m;
   wb_m2s_t     dbus_m2s;
   wb_s2m_t     dbus_s2m;
   logic        uart_tx;

   // What the open transfer on each port should return
   logic        ibus_chk;
   logic [31:0] ibus_exp;
   logic        ibus_exp_err;
   logic        dbus_chk;
   logic [31:0] dbus_exp;
   logic        dbus_exp_err;
   time         ibus_done_t;
   time         dbus_done_t;

   logic [31:0] ref_mem [2**MEM_ADR_BITS];
   logic [7:0]  word_idx [N_WORDS];
   logic [7:0]  frame_q [$];
   logic        frame_done = 1'b0;
   logic        frame_start;
   logic        frame_stop;
   logic        frame_has_exp;
   logic [7:0]  frame_byte;
   logic [7:0]  frame_exp;
   int          frames_seen = 0;
   int          xfers = 0;
   int          errors = 0;
   int          seed = 89999;

   always #5 clk = ~clk;

   soc_top soc_top_i (
      .wb_clk_i   (clk),
      .rst_n_i    (rst_n),
      .ibus_m2s_i (ibus_m2s),
      .ibus_s2m_o (ibus_s2m),
      .dbus_m2s_i (dbus_m2s),
      .dbus_s2m_o (dbus_s2m),
      .uart_tx_o  (uart_tx)
   );

   ///////////////////////////////////////////////////////////////////////
   // Checks
   ///////////////////////////////////////////////////////////////////////

   a_no_ack_err: assert property (@(posedge clk) disable iff (!rst_n)
      !(ibus_s2m.ack && ibus_s2m.err) && !(dbus_s2m.ack && dbus_s2m.err))
      else begin
         errors++;
         $display("A master port saw ack and err in the same cycle");
      end

   a_ibus_open: assert property (@(posedge clk) disable iff (!rst_n)
      (ibus_s2m.ack || ibus_s2m.err) |-> $past(ibus_m2s.cyc && ibus_m2s.stb))
      else begin
         errors++;
         $display("Instruction port answered without an open strobe");
      end

   a_dbus_open: assert property (@(posedge clk) disable iff (!rst_n)
      (dbus_s2m.ack || dbus_s2m.err) |-> $past(dbus_m2s.cyc && dbus_m2s.stb))
      else begin
         errors++;
         $display("Data port answered without an open strobe");
      end

   a_ibus_kind: assert property (@(posedge clk) disable iff (!rst_n)
      (ibus_s2m.ack || ibus_s2m.err) |-> ibus_s2m.err == ibus_exp_err)
      else begin
         errors++;
         $display("ERROR ibus_s2m.err got %h expected %h",
                  $sampled(ibus_s2m.err), $sampled(ibus_exp_err));
      end

   a_dbus_kind: assert property (@(posedge clk) disable iff (!rst_n)
      (dbus_s2m.ack || dbus_s2m.err) |-> dbus_s2m.err == dbus_exp_err)
      else begin
         errors++;
         $display("ERROR dbus_s2m.err got %h expected %h",
                  $sampled(dbus_s2m.err), $sampled(dbus_exp_err));
      end

   a_ibus_dat: assert property (@(posedge clk) disable iff (!rst_n)
      ibus_s2m.ack && ibus_chk |-> ibus_s2m.dat === ibus_exp)
      else begin
         errors++;
         $display("ERROR ibus_s2m.dat got %h expected %h",
                  $sampled(ibus_s2m.dat), $sampled(ibus_exp));
      end

   a_dbus_dat: assert property (@(posedge clk) disable iff (!rst_n)
      dbus_s2m.ack && dbus_chk |-> dbus_s2m.dat === dbus_exp)
      else begin
         errors++;
         $display("ERROR dbus_s2m.dat got %h expected %h",
                  $sampled(dbus_s2m.dat), $sampled(dbus_exp));
      end

   a_frame: assert property (@(posedge clk)
      frame_done |-> frame_has_exp && frame_start === 1'b0 && frame_stop === 1'b1
                     && frame_byte === frame_exp)
      else begin
         errors++;
         if (!frame_has_exp) begin
            $display("A serial frame appeared with no byte written");
         end else begin
            $display("ERROR uart_tx_o start %h byte %h stop %h expected byte %h",
                     frame_start, frame_byte, frame_stop, frame_exp);
         end
      end

   ///////////////////////////////////////////////////////////////////////
   // Master drivers and helpers
   ///////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] ram_adr(input logic [7:0] idx);
      return RAM_BASE | (32'(idx) << 2);
   endfunction

   // One lane per sel bit
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  sel);
      logic [31:0] word;
      word = old_word;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            word[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return word;
   endfunction

   task automatic ibus_xfer(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input logic we, input logic chk,
                            input logic [31:0] exp, input logic exp_err);
      int cycles;
      ibus_chk     = chk;
      ibus_exp     = exp;
      ibus_exp_err = exp_err;
      ibus_m2s     = '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
      cycles       = 0;
      do begin
         @(posedge clk);
         #1;
         cycles++;
      end while (!ibus_s2m.ack && !ibus_s2m.err && cycles < XFER_LIMIT);
      if (!ibus_s2m.ack && !ibus_s2m.err) begin
         errors++;
         $display("Instruction port got no response at address %h", adr);
      end
      ibus_done_t = $time;
      ibus_m2s    = '0;
      xfers++;
      @(posedge clk);
      #1;
   endtask

   task automatic dbus_xfer(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input logic we, input logic chk,
                            input logic [31:0] exp, input logic exp_err);
      int cycles;
      dbus_chk     = chk;
      dbus_exp     = exp;
      dbus_exp_err = exp_err;
      dbus_m2s     = '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
      cycles       = 0;
      do begin
         @(posedge clk);
         #1;
         cycles++;
      end while (!dbus_s2m.ack && !dbus_s2m.err && cycles < XFER_LIMIT);
      if (!dbus_s2m.ack && !dbus_s2m.err) begin
         errors++;
         $display("Data port got no response at address %h", adr);
      end
      dbus_done_t = $time;
      dbus_m2s    = '0;
      xfers++;
      @(posedge clk);
      #1;
   endtask

   task automatic wait_frames();
      int cycles;
      cycles = 0;
      while (frame_q.size() != 0 && cycles < FRAME_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      if (frame_q.size() != 0) begin
         errors++;
         $display("%0d serial frames still missing", frame_q.size());
      end
      // Let the last stop bit run out
      repeat (2 * UART_CLKS_PER_BIT) @(posedge clk);
      #1;
   endtask

   // Serial line decoder sampling near bit centers
   initial begin : serial_decoder
      logic [7:0] rx;
      wait (rst_n === 1'b1);
      forever begin
         @(negedge uart_tx);
         repeat (UART_CLKS_PER_BIT / 2) @(negedge clk);
         frame_start = uart_tx;
         for (int i = 0; i < 8; i++) begin
            repeat (UART_CLKS_PER_BIT) @(negedge clk);
            rx[i] = uart_tx;
         end
         repeat (UART_CLKS_PER_BIT) @(negedge clk);
         frame_stop    = uart_tx;
         frame_byte    = rx;
         frame_has_exp = frame_q.size() > 0;
         if (frame_has_exp) begin
            frame_exp = frame_q.pop_front();
         end
         frames_seen++;
         frame_done = 1'b1;
         @(negedge clk);
         frame_done = 1'b0;
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Run timed out after %0d cycles", WATCHDOG_CYCLES);
      $display("TEST FAIL");
      $finish;
   end

   ///////////////////////////////////////////////////////////////////////
   // Stimulus
   ///////////////////////////////////////////////////////////////////////

   initial begin : stimulus
      logic [31:0] dat;
      logic [3:0]  sel;
      logic [7:0]  idx;
      logic [7:0]  tx_byte [4];
      rst_n        = 1'b0;
      ibus_m2s     = '0;
      dbus_m2s     = '0;
      ibus_chk     = 1'b0;
      ibus_exp     = '0;
      ibus_exp_err = 1'b0;
      dbus_chk     = 1'b0;
      dbus_exp     = '0;
      dbus_exp_err = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;

      // Full words first so no byte stays unknown
      for (int i = 0; i < N_WORDS; i++) begin
         word_idx[i] = $random(seed);
         dat = $random(seed);
         ref_mem[word_idx[i]] = dat;
         dbus_xfer(ram_adr(word_idx[i]), dat, 4'hF, 1'b1, 1'b0, '0, 1'b0);
      end
      for (int i = 0; i < N_RAND; i++) begin
         idx = word_idx[$unsigned($random(seed)) % N_WORDS];
         dat = $random(seed);
         sel = $random(seed);
         ref_mem[idx] = merge_bytes(ref_mem[idx], dat, sel);
         dbus_xfer(ram_adr(idx), dat, sel, 1'b1, 1'b0, '0, 1'b0);
      end
      for (int i = 0; i < N_WORDS; i++) begin
         ibus_xfer(ram_adr(word_idx[i]), '0, 4'hF, 1'b0, 1'b1, ref_mem[word_idx[i]], 1'b0);
      end

      // Both masters in the same cycle
      for (int r = 0; r < N_CONC; r++) begin
         fork
            dbus_xfer(ram_adr(word_idx[r]), '0, 4'hF, 1'b0, 1'b1,
                      ref_mem[word_idx[r]], 1'b0);
            ibus_xfer(ram_adr(word_idx[N_WORDS-1-r]), '0, 4'hF, 1'b0, 1'b1,
                      ref_mem[word_idx[N_WORDS-1-r]], 1'b0);
         join
         if (dbus_done_t >= ibus_done_t) begin
            errors++;
            $display("Data master was not answered first in round %0d", r);
         end
      end

      for (int i = 0; i < 4; i++) begin
         tx_byte[i] = $random(seed);
      end
      // Lanes 0 and 2 both reach the TX offset
      frame_q.push_back(tx_byte[0]);
      dbus_xfer(UART_BASE, {24'd0, tx_byte[0]}, 4'b0001, 1'b1, 1'b0, '0, 1'b0);
      frame_q.push_back(tx_byte[1]);
      dbus_xfer(UART_BASE, {8'd0, tx_byte[1], 16'd0}, 4'b0100, 1'b1, 1'b0, '0, 1'b0);
      ibus_xfer(UART_BASE, '0, 4'b0001, 1'b0, 1'b1, {24'd0, tx_byte[1]}, 1'b0);
      ibus_xfer(UART_BASE, '0, 4'b0100, 1'b0, 1'b1, {8'd0, tx_byte[1], 16'd0}, 1'b0);
      wait_frames();

      // Status read while busy and a write into the busy shifter
      frame_q.push_back(tx_byte[2]);
      dbus_xfer(UART_BASE, {24'd0, tx_byte[2]}, 4'b0001, 1'b1, 1'b0, '0, 1'b0);
      dbus_xfer(UART_BASE, '0, STATUS_SEL, 1'b0, 1'b1, STATUS_BUSY, 1'b0);
      frame_q.push_back(tx_byte[3]);
      dbus_xfer(UART_BASE, {8'd0, tx_byte[3], 16'd0}, 4'b0100, 1'b1, 1'b0, '0, 1'b0);
      wait_frames();
      dbus_xfer(UART_BASE, '0, STATUS_SEL, 1'b0, 1'b1, 32'd0, 1'b0);

      // Unmapped space and a two-lane UART write
      dbus_xfer(32'h4000_0000, $random(seed), 4'hF, 1'b1, 1'b0, '0, 1'b1);
      ibus_xfer(RAM_BASE + RAM_MASK + 1, '0, 4'hF, 1'b0, 1'b0, '0, 1'b1);
      dbus_xfer(UART_BASE, $random(seed), 4'b0011, 1'b1, 1'b0, '0, 1'b1);
      repeat (12 * UART_CLKS_PER_BIT) @(posedge clk);

      if (frames_seen != N_FRAMES) begin
         errors++;
         $display("Saw %0d serial frames where %0d were written", frames_seen, N_FRAMES);
      end
      $display("Done: %0d transfers, %0d frames, %0d errors", xfers, frames_seen, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule
